// ==== mmu.f ====
rtl/mmu_pkg.sv
rtl/tlb_search_if.sv
rtl/mmu_cfg_regs.sv
rtl/tlb_entry_array.sv
rtl/addr_translate.sv
rtl/mmu_top.sv
testbench/tb_clock.sv
testbench/mmu_assert.sv
testbench/tb_mmu.sv

// ==== Makefile ====
TOP := tb_mmu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f mmu.f --top-module $(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// ==== testbench/tb_mmu.sv ====
`default_nettype none

module tb_mmu
    import mmu_pkg::*;
();

    localparam int TLBNUM = 16;

    logic               clk;
    logic               reset;
    logic               cfg_we_i;
    logic [13:0]        cfg_num_i;
    logic [31:0]        cfg_wdata_i;
    logic               tlb_we_i;
    logic [3:0]         tlb_w_index_i;
    tlb_entry_t         tlb_w_entry_i;
    logic               if_req_i;
    logic [31:0]        if_vaddr_i;
    logic               if_store_i;
    logic               if_valid_o;
    logic [31:0]        if_paddr_o;
    logic [5:0]         if_ecode_o;
    logic               mem_req_i;
    logic [31:0]        mem_vaddr_i;
    logic               mem_store_i;
    logic               mem_valid_o;
    logic [31:0]        mem_paddr_o;
    logic [5:0]         mem_ecode_o;

    // reference state
    logic [1:0]  m_plv;
    logic        m_da;
    logic [9:0]  m_asid;
    dmw_t        m_dmw0;
    dmw_t        m_dmw1;
    tlb_entry_t  m_tlb [TLBNUM];

    // expected {code, paddr} per port
    logic [37:0] if_q[$];
    logic [37:0] mem_q[$];
    logic [31:0] lfsr = 32'hae8;
    int          errors = 0;
    int          proto_errors = 0;
    int          waited;

    tb_clock #(.PERIOD(8)) u_clock (.clk_o(clk));

    mmu_top #(.TLBNUM(TLBNUM)) uut (
        .clk           (clk),
        .reset         (reset),
        .cfg_we_i      (cfg_we_i),
        .cfg_num_i     (cfg_num_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .tlb_we_i      (tlb_we_i),
        .tlb_w_index_i (tlb_w_index_i),
        .tlb_w_entry_i (tlb_w_entry_i),
        .if_req_i      (if_req_i),
        .if_vaddr_i    (if_vaddr_i),
        .if_store_i    (if_store_i),
        .if_valid_o    (if_valid_o),
        .if_paddr_o    (if_paddr_o),
        .if_ecode_o    (if_ecode_o),
        .mem_req_i     (mem_req_i),
        .mem_vaddr_i   (mem_vaddr_i),
        .mem_store_i   (mem_store_i),
        .mem_valid_o   (mem_valid_o),
        .mem_paddr_o   (mem_paddr_o),
        .mem_ecode_o   (mem_ecode_o)
    );

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // small vppn pool so lookups hit written entries
    function automatic logic [18:0] pick_vppn();
        return {1'b1, 2'(lfsr_bits(2)), 14'h0a5, 2'(lfsr_bits(2))};
    endfunction

    function automatic logic [31:0] rand_vaddr(input bit pooled);
        if (!pooled || lfsr_bits(3) == 0) begin
            return lfsr_bits(32);
        end
        return {pick_vppn(), 13'(lfsr_bits(13))};
    endfunction

    function automatic tlb_page_t rand_page();
        tlb_page_t p;
        p.ppn = 20'(lfsr_bits(20));
        p.plv = 2'(lfsr_bits(2));
        p.d   = lfsr_bits(1) != 0;
        p.v   = lfsr_bits(3) != 0;
        return p;
    endfunction

    function automatic tlb_entry_t rand_entry();
        tlb_entry_t t;
        t.e     = lfsr_bits(3) != 0;
        t.vppn  = pick_vppn();
        t.asid  = 10'(lfsr_bits(2));
        t.g     = lfsr_bits(2) == 0;
        t.page0 = rand_page();
        t.page1 = rand_page();
        return t;
    endfunction

    task automatic ref_cfg_write(input logic [13:0] num, input logic [31:0] w);
        case (num)
            CSR_CRMD: begin
                m_plv = w[1:0];
                m_da  = w[3];
            end
            CSR_ASID: m_asid = w[9:0];
            CSR_DMW0: m_dmw0 = '{plv_mask: w[3:0], pseg: w[27:25], vseg: w[31:29]};
            CSR_DMW1: m_dmw1 = '{plv_mask: w[3:0], pseg: w[27:25], vseg: w[31:29]};
            default: ;
        endcase
    endtask

    // returns {code, paddr}
    function automatic logic [37:0] ref_translate(input logic [31:0] va, input bit fetch,
                                                  input bit store);
        logic [5:0]  code;
        logic [31:0] pa;
        tlb_page_t   pg;
        int          hit;
        code = ECODE_NONE;
        pa = va;
        hit = -1;
        if (m_da) begin
            return {code, pa};
        end
        if (m_dmw0.vseg == va[31:29] && m_dmw0.plv_mask[m_plv]) begin
            return {code, m_dmw0.pseg, va[28:0]};
        end
        if (m_dmw1.vseg == va[31:29] && m_dmw1.plv_mask[m_plv]) begin
            return {code, m_dmw1.pseg, va[28:0]};
        end
        for (int i = 0; i < TLBNUM && hit < 0; i++) begin
            if (m_tlb[i].e && m_tlb[i].vppn == va[31:13]
                    && (m_tlb[i].g || m_tlb[i].asid == m_asid)) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            return {ECODE_TLBR, va};
        end
        pg = va[12] ? m_tlb[hit].page1 : m_tlb[hit].page0;
        if (!pg.v) begin
            code = fetch ? ECODE_PIF : (store ? ECODE_PIS : ECODE_PIL);
        end else if (m_plv > pg.plv) begin
            code = ECODE_PPI;
        end else if (store && !pg.d) begin
            code = ECODE_PME;
        end else begin
            pa = {pg.ppn, va[11:0]};
        end
        return {code, pa};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s: got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic take_result(input bit is_fetch, input logic valid, input logic [31:0] paddr,
                               input logic [5:0] code);
        logic [37:0] exp;
        string       name;
        int          pending;
        name = is_fetch ? "fetch" : "data";
        pending = is_fetch ? if_q.size() : mem_q.size();
        if (valid && pending == 0) begin
            $display("t=%0t %s port returned a result with no request outstanding", $time, name);
            proto_errors++;
        end else if (!valid && pending != 0) begin
            $display("t=%0t %s port gave no result one cycle after its request", $time, name);
            proto_errors++;
        end
        if (pending != 0) begin
            if (is_fetch) begin
                exp = if_q.pop_front();
            end else begin
                exp = mem_q.pop_front();
            end
            if (valid) begin
                check_value({name, " code"}, 32'(code), 32'(exp[37:32]));
                if (exp[37:32] == ECODE_NONE) begin
                    check_value({name, " paddr"}, paddr, exp[31:0]);
                end
            end
        end
    endtask

    task automatic sample_outputs();
        @(posedge clk);
        #1;
        take_result(1'b1, if_valid_o, if_paddr_o, if_ecode_o);
        take_result(1'b0, mem_valid_o, mem_paddr_o, mem_ecode_o);
    endtask

    task automatic drive_cycle(input bit full);
        logic [2:0]  sel;
        logic [31:0] w;
        sample_outputs();
        if_req_i = lfsr_bits(2) != 0;
        if_vaddr_i = rand_vaddr(full);
        if_store_i = lfsr_bits(1) != 0;
        mem_req_i = lfsr_bits(2) != 0;
        mem_vaddr_i = rand_vaddr(full);
        mem_store_i = lfsr_bits(1) != 0;
        // requests see the state before this cycle's writes
        if (if_req_i) begin
            if_q.push_back(ref_translate(if_vaddr_i, 1'b1, if_store_i));
        end
        if (mem_req_i) begin
            mem_q.push_back(ref_translate(mem_vaddr_i, 1'b0, mem_store_i));
        end
        cfg_we_i = full && lfsr_bits(3) == 0;
        tlb_we_i = full && lfsr_bits(2) == 0;
        if (cfg_we_i) begin
            sel = 3'(lfsr_bits(3));
            w = lfsr_bits(32);
            case (sel)
                3'd0, 3'd1: cfg_num_i = CSR_CRMD;
                3'd2: cfg_num_i = CSR_ASID;
                3'd3, 3'd4: cfg_num_i = CSR_DMW0;
                3'd5, 3'd6: cfg_num_i = CSR_DMW1;
                default: cfg_num_i = 14'(lfsr_bits(14));
            endcase
            // mostly mapped mode and a small asid pool
            if (cfg_num_i == CSR_CRMD) begin
                w[3] = lfsr_bits(3) == 0;
            end
            if (cfg_num_i == CSR_ASID) begin
                w[9:2] = '0;
            end
            cfg_wdata_i = w;
            ref_cfg_write(cfg_num_i, w);
        end
        if (tlb_we_i) begin
            tlb_w_index_i = 4'(lfsr_bits(4));
            tlb_w_entry_i = rand_entry();
            m_tlb[tlb_w_index_i] = tlb_w_entry_i;
        end
    endtask

    initial begin
        reset = 1'b1;
        cfg_we_i = 1'b0;
        cfg_num_i = '0;
        cfg_wdata_i = '0;
        tlb_we_i = 1'b0;
        tlb_w_index_i = '0;
        tlb_w_entry_i = '0;
        if_req_i = 1'b0;
        if_vaddr_i = '0;
        if_store_i = 1'b0;
        mem_req_i = 1'b0;
        mem_vaddr_i = '0;
        mem_store_i = 1'b0;
        m_plv = '0;
        m_da = 1'b1;
        m_asid = '0;
        m_dmw0 = '0;
        m_dmw1 = '0;
        for (int i = 0; i < TLBNUM; i++) begin
            m_tlb[i] = '0;
        end
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        #1;
        reset = 1'b0;

        // direct mode straight out of reset
        for (int i = 0; i < 40; i++) begin
            drive_cycle(1'b0);
        end
        // windows, tlb writes and lookups mixed
        for (int i = 0; i < 800; i++) begin
            drive_cycle(1'b1);
        end

        // the last requests are taken at this edge
        sample_outputs();
        if_req_i = 1'b0;
        mem_req_i = 1'b0;
        cfg_we_i = 1'b0;
        tlb_we_i = 1'b0;
        waited = 0;
        while ((if_q.size() != 0 || mem_q.size() != 0) && waited < 10) begin
            sample_outputs();
            waited++;
        end
        if (if_q.size() != 0 || mem_q.size() != 0) begin
            $display("timeout: results still outstanding after %0d cycles", waited);
            proto_errors++;
        end

        $display("value errors: %0d, protocol errors: %0d", errors, proto_errors);
        if (errors == 0 && proto_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/mmu_assert.sv ====
`default_nettype none

module mmu_assert
    import mmu_pkg::*;
(
    input logic               clk,
    input logic               reset,
    input logic               da_i,
    input logic               if_req_i,
    input logic               if_valid_i,
    input logic [ECODE_W-1:0] if_ecode_i,
    input logic               mem_req_i,
    input logic               mem_valid_i,
    input logic [ECODE_W-1:0] mem_ecode_i
);

    // each pulse exactly one cycle after its request
    assert property (@(posedge clk) disable iff (reset) if_req_i |=> if_valid_i)
        else $error("fetch request produced no result pulse");
    assert property (@(posedge clk) disable iff (reset) if_valid_i |-> $past(if_req_i && !reset))
        else $error("fetch result pulse without a request");
    assert property (@(posedge clk) disable iff (reset) mem_req_i |=> mem_valid_i)
        else $error("data request produced no result pulse");
    assert property (@(posedge clk) disable iff (reset) mem_valid_i |-> $past(mem_req_i && !reset))
        else $error("data result pulse without a request");

    assert property (@(posedge clk) reset |=> !if_valid_i && !mem_valid_i)
        else $error("result pulse right after a reset cycle");

    // direct mode never faults
    assert property (@(posedge clk) disable iff (reset)
        if_req_i && da_i |=> if_ecode_i == ECODE_NONE)
        else $error("fetch fault in direct mode");
    assert property (@(posedge clk) disable iff (reset)
        mem_req_i && da_i |=> mem_ecode_i == ECODE_NONE)
        else $error("data fault in direct mode");

endmodule

bind mmu_top mmu_assert u_assert (
    .clk         (clk),
    .reset       (reset),
    .da_i        (cfg.da),
    .if_req_i    (if_req_i),
    .if_valid_i  (if_valid_o),
    .if_ecode_i  (if_ecode_o),
    .mem_req_i   (mem_req_i),
    .mem_valid_i (mem_valid_o),
    .mem_ecode_i (mem_ecode_o)
);

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== rtl/mmu_top.sv ====
`default_nettype none

module mmu_top
    import mmu_pkg::*;
#(
    parameter int TLBNUM = 16,
    localparam int IDX_W = $clog2(TLBNUM)
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 cfg_we_i,
    input  logic [CSR_NUM_W-1:0] cfg_num_i,
    input  logic [31:0]          cfg_wdata_i,

    input  logic                 tlb_we_i,
    input  logic [IDX_W-1:0]     tlb_w_index_i,
    input  tlb_entry_t           tlb_w_entry_i,

    // fetch port
    input  logic                 if_req_i,
    input  logic [VADDR_W-1:0]   if_vaddr_i,
    input  logic                 if_store_i,
    output logic                 if_valid_o,
    output logic [PADDR_W-1:0]   if_paddr_o,
    output logic [ECODE_W-1:0]   if_ecode_o,

    // load/store port
    input  logic                 mem_req_i,
    input  logic [VADDR_W-1:0]   mem_vaddr_i,
    input  logic                 mem_store_i,
    output logic                 mem_valid_o,
    output logic [PADDR_W-1:0]   mem_paddr_o,
    output logic [ECODE_W-1:0]   mem_ecode_o
);

    mmu_cfg_t cfg;

    tlb_search_if #(.TLBNUM(TLBNUM)) fetch_s ();
    tlb_search_if #(.TLBNUM(TLBNUM)) data_s ();

    mmu_cfg_regs u_cfg_regs (
        .clk         (clk),
        .reset       (reset),
        .cfg_we_i    (cfg_we_i),
        .cfg_num_i   (cfg_num_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_o       (cfg)
    );

    tlb_entry_array #(.TLBNUM(TLBNUM)) u_tlb (
        .clk       (clk),
        .reset     (reset),
        .we_i      (tlb_we_i),
        .w_index_i (tlb_w_index_i),
        .w_entry_i (tlb_w_entry_i),
        .fetch_s   (fetch_s.responder),
        .data_s    (data_s.responder)
    );

    addr_translate #(.IS_FETCH(1'b1)) u_fetch_xlate (
        .clk     (clk),
        .reset   (reset),
        .req_i   (if_req_i),
        .vaddr_i (if_vaddr_i),
        .store_i (if_store_i),
        .cfg_i   (cfg),
        .tlb     (fetch_s.requester),
        .valid_o (if_valid_o),
        .paddr_o (if_paddr_o),
        .ecode_o (if_ecode_o)
    );

    addr_translate #(.IS_FETCH(1'b0)) u_data_xlate (
        .clk     (clk),
        .reset   (reset),
        .req_i   (mem_req_i),
        .vaddr_i (mem_vaddr_i),
        .store_i (mem_store_i),
        .cfg_i   (cfg),
        .tlb     (data_s.requester),
        .valid_o (mem_valid_o),
        .paddr_o (mem_paddr_o),
        .ecode_o (mem_ecode_o)
    );

endmodule

`default_nettype wire

// ==== rtl/addr_translate.sv ====
`default_nettype none

module addr_translate
    import mmu_pkg::*;
#(
    parameter bit IS_FETCH = 1'b0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req_i,
    input  logic [VADDR_W-1:0] vaddr_i,
    input  logic               store_i,
    input  mmu_cfg_t           cfg_i,
    tlb_search_if.requester    tlb,
    output logic               valid_o,
    output logic [PADDR_W-1:0] paddr_o,
    output logic [ECODE_W-1:0] ecode_o
);

    logic [PADDR_W-1:0] paddr_d;
    logic [ECODE_W-1:0] ecode_d;
    logic [ECODE_W-1:0] inval_code;

    function automatic logic dmw_hit(
        input dmw_t             w,
        input logic [2:0]       seg,
        input logic [PLV_W-1:0] plv
    );
        return (w.vseg == seg) && w.plv_mask[plv];
    endfunction

    // search request, bit 12 picks the odd page
    assign tlb.vppn     = vaddr_i[31:13];
    assign tlb.odd_page = vaddr_i[12];
    assign tlb.asid     = cfg_i.asid;

    assign inval_code = IS_FETCH ? ECODE_PIF : (store_i ? ECODE_PIS : ECODE_PIL);

    always_comb begin
        paddr_d = vaddr_i;
        ecode_d = ECODE_NONE;
        if (!cfg_i.da) begin
            if (dmw_hit(cfg_i.dmw0, vaddr_i[31:29], cfg_i.plv)) begin
                paddr_d = {cfg_i.dmw0.pseg, vaddr_i[28:0]};
            end else if (dmw_hit(cfg_i.dmw1, vaddr_i[31:29], cfg_i.plv)) begin
                paddr_d = {cfg_i.dmw1.pseg, vaddr_i[28:0]};
            end else if (!tlb.found) begin
                ecode_d = ECODE_TLBR;
            end else if (!tlb.page.v) begin
                ecode_d = inval_code;
            end else if (cfg_i.plv > tlb.page.plv) begin
                ecode_d = ECODE_PPI;
            end else if (store_i && !tlb.page.d) begin
                ecode_d = ECODE_PME;
            end else begin
                paddr_d = {tlb.page.ppn, vaddr_i[11:0]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            paddr_o <= paddr_d;
            ecode_o <= ecode_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tlb_entry_array.sv ====
`default_nettype none

module tlb_entry_array
    import mmu_pkg::*;
#(
    parameter int TLBNUM = 16,
    localparam int IDX_W = $clog2(TLBNUM)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             we_i,
    input  logic [IDX_W-1:0] w_index_i,
    input  tlb_entry_t       w_entry_i,
    tlb_search_if.responder  fetch_s,
    tlb_search_if.responder  data_s
);

    // per-entry valid bits, cleared on reset
    logic [TLBNUM-1:0] ent_e;
    tlb_entry_t        ent [TLBNUM];

    logic             f_found;
    logic [IDX_W-1:0] f_idx;
    logic             d_found;
    logic [IDX_W-1:0] d_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_e <= '0;
        end else if (we_i) begin
            ent_e[w_index_i] <= w_entry_i.e;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            ent[w_index_i] <= w_entry_i;
        end
    end

    // returns {found, index} with the lowest matching index winning
    function automatic logic [IDX_W:0] search(
        input logic [VPPN_W-1:0] vppn,
        input logic [ASID_W-1:0] asid
    );
        logic [IDX_W:0] res;
        res = '0;
        for (int i = TLBNUM - 1; i >= 0; i--) begin
            if (ent_e[i] && ent[i].vppn == vppn && (ent[i].g || ent[i].asid == asid)) begin
                res = {1'b1, IDX_W'(i)};
            end
        end
        return res;
    endfunction

    always_comb begin
        {f_found, f_idx} = search(fetch_s.vppn, fetch_s.asid);
        {d_found, d_idx} = search(data_s.vppn, data_s.asid);
    end

    assign fetch_s.found = f_found;
    assign fetch_s.index = f_idx;
    assign fetch_s.page  = fetch_s.odd_page ? ent[f_idx].page1 : ent[f_idx].page0;

    assign data_s.found = d_found;
    assign data_s.index = d_idx;
    assign data_s.page  = data_s.odd_page ? ent[d_idx].page1 : ent[d_idx].page0;

endmodule

`default_nettype wire

// ==== rtl/mmu_cfg_regs.sv ====
`default_nettype none

module mmu_cfg_regs
    import mmu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfg_we_i,
    input  logic [CSR_NUM_W-1:0] cfg_num_i,
    input  logic [31:0]          cfg_wdata_i,
    output mmu_cfg_t             cfg_o
);

    logic [PLV_W-1:0]  plv_q;
    logic              da_q;
    logic [ASID_W-1:0] asid_q;
    dmw_t              dmw0_q;
    dmw_t              dmw1_q;

    // window layout: mask 3:0, pseg 27:25, vseg 31:29
    function automatic dmw_t to_dmw(input logic [31:0] w);
        dmw_t d;
        d.plv_mask = w[3:0];
        d.pseg     = w[27:25];
        d.vseg     = w[31:29];
        return d;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            plv_q  <= '0;
            da_q   <= 1'b1;
            asid_q <= '0;
            dmw0_q <= '0;
            dmw1_q <= '0;
        end else if (cfg_we_i) begin
            case (cfg_num_i)
                CSR_CRMD: begin
                    plv_q <= cfg_wdata_i[1:0];
                    da_q  <= cfg_wdata_i[3];
                end
                CSR_ASID: begin
                    asid_q <= cfg_wdata_i[9:0];
                end
                CSR_DMW0: begin
                    dmw0_q <= to_dmw(cfg_wdata_i);
                end
                CSR_DMW1: begin
                    dmw1_q <= to_dmw(cfg_wdata_i);
                end
                // unknown numbers dropped
                default: ;
            endcase
        end
    end

    assign cfg_o = '{
        plv:  plv_q,
        da:   da_q,
        asid: asid_q,
        dmw0: dmw0_q,
        dmw1: dmw1_q
    };

endmodule

`default_nettype wire

// ==== rtl/tlb_search_if.sv ====
`default_nettype none

interface tlb_search_if
    import mmu_pkg::*;
#(
    parameter int TLBNUM = 16
);
    localparam int IDX_W = $clog2(TLBNUM);

    logic [VPPN_W-1:0] vppn;
    logic              odd_page;
    logic [ASID_W-1:0] asid;
    logic              found;
    // index of the winning entry
    logic [IDX_W-1:0]  index;
    tlb_page_t         page;

    modport requester (output vppn, odd_page, asid, input found, index, page);
    modport responder (input vppn, odd_page, asid, output found, index, page);

endinterface

`default_nettype wire

// ==== rtl/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

    localparam int VADDR_W   = 32;
    localparam int PADDR_W   = 32;
    localparam int VPPN_W    = 19;
    localparam int PPN_W     = 20;
    localparam int ASID_W    = 10;
    localparam int PLV_W     = 2;
    localparam int CSR_NUM_W = 14;
    localparam int ECODE_W   = 6;

    // configuration register numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD = 14'h000;
    localparam logic [CSR_NUM_W-1:0] CSR_ASID = 14'h018;
    localparam logic [CSR_NUM_W-1:0] CSR_DMW0 = 14'h180;
    localparam logic [CSR_NUM_W-1:0] CSR_DMW1 = 14'h181;

    // exception codes
    localparam logic [ECODE_W-1:0] ECODE_NONE = 6'h00;
    localparam logic [ECODE_W-1:0] ECODE_PIL  = 6'h01;
    localparam logic [ECODE_W-1:0] ECODE_PIS  = 6'h02;
    localparam logic [ECODE_W-1:0] ECODE_PIF  = 6'h03;
    localparam logic [ECODE_W-1:0] ECODE_PME  = 6'h04;
    localparam logic [ECODE_W-1:0] ECODE_PPI  = 6'h07;
    localparam logic [ECODE_W-1:0] ECODE_TLBR = 6'h3f;

    // direct-mapped window, bit n of plv_mask allows level n
    typedef struct packed {
        logic [3:0] plv_mask;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    typedef struct packed {
        logic [PLV_W-1:0]  plv;
        logic              da;
        logic [ASID_W-1:0] asid;
        dmw_t              dmw0;
        dmw_t              dmw1;
    } mmu_cfg_t;

    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [PLV_W-1:0] plv;
        logic             d;
        logic             v;
    } tlb_page_t;

    // page0 maps the even 4 KiB page, page1 the odd one
    typedef struct packed {
        logic              e;
        logic [VPPN_W-1:0] vppn;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

endpackage

`default_nettype wire
